// ==== source/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // Address and data share one 32-bit bus word
    typedef logic [31:0] bus_word_t;

    // Command field opcodes
    typedef enum logic [2:0] {
        CMD_IDLE = 3'b000,
        CMD_READ = 3'b010, // Request beat
        CMD_RESP = 3'b011  // Data beat
    } bus_cmd_t;

    // Bid levels on reqout
    typedef enum logic [1:0] {
        BID_NONE = 2'b00,
        BID_LOW  = 2'b01, // Normal refill
        BID_HIGH = 2'b11  // FIFO running dry
    } bus_bid_t;

    // Words per read burst
    localparam int BURST_BEATS = 4;

    // lenout encodes beats minus one
    localparam logic [1:0] BURST_LEN = 2'(BURST_BEATS - 1);

endpackage

`default_nettype wire

// ==== source/video_pkg.sv ====
`default_nettype none

package video_pkg;

    // Bits per colour channel
    localparam int COLOR_W = 8;

    // 24-bit RGB, red in the top byte
    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } pixel_t;

    // Shown when no pixel is available or outside the active area
    localparam pixel_t BLACK = '0;

    // Fetcher sequence
    typedef enum logic [1:0] {
        F_IDLE = 2'd0, // Wait for FIFO room
        F_BID  = 2'd1, // Bid until granted
        F_CMD  = 2'd2, // Command beat
        F_DATA = 2'd3  // Collect returned words
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== source/frame_fetch.sv ====
`default_nettype none

module frame_fetch #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480,
    parameter int FIFO_DEPTH = 64,
    parameter bus_pkg::bus_word_t FRAME_BASE = 32'h0000_0000
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         selin,
    input  bus_pkg::bus_cmd_t            cmdin,
    input  bus_pkg::bus_word_t           addrdatain,
    input  logic                         ackin,
    input  logic [$clog2(FIFO_DEPTH):0]  fifo_level,
    output bus_pkg::bus_bid_t            reqout,
    output bus_pkg::bus_cmd_t            cmdout,
    output logic [1:0]                   lenout,
    output bus_pkg::bus_word_t           addrdataout,
    output logic                         wr_en,
    output video_pkg::pixel_t            wr_data
);
    import bus_pkg::*;
    import video_pkg::*;

    localparam int LW = $clog2(FIFO_DEPTH) + 1;

    // Room for a full burst, and the urgent refill threshold
    localparam logic [LW-1:0] ROOM_MAX = LW'(FIFO_DEPTH - BURST_BEATS);
    localparam logic [LW-1:0] URGENT_LEVEL = LW'(FIFO_DEPTH / 4);

    // Start address of the last burst in the frame
    localparam bus_word_t FRAME_LAST =
        FRAME_BASE + bus_word_t'(H_ACTIVE * V_ACTIVE - BURST_BEATS);

    fetch_state_t state;
    logic [1:0]   beat_cnt;
    bus_word_t    addr;

    // A response beat belonging to our burst
    assign wr_en = (state == F_DATA) && selin && (cmdin == CMD_RESP);
    assign wr_data = pixel_t'(addrdatain[$bits(pixel_t)-1:0]);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= F_IDLE;
            beat_cnt <= 2'd0;
            addr <= FRAME_BASE;
        end else begin
            case (state)
                F_IDLE: begin
                    if (fifo_level <= ROOM_MAX) begin
                        state <= F_BID;
                    end
                end
                F_BID: begin
                    if (ackin) begin
                        state <= F_CMD;
                    end
                end
                F_CMD: begin
                    state <= F_DATA;
                end
                F_DATA: begin
                    if (wr_en) begin
                        beat_cnt <= beat_cnt + 2'd1; // Wraps back to zero on the last beat
                        if (beat_cnt == BURST_LEN) begin
                            state <= F_IDLE;
                            addr <= (addr == FRAME_LAST) ? FRAME_BASE
                                                         : addr + bus_word_t'(BURST_BEATS);
                        end
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // Bus outputs decoded from the state
    always_comb begin
        reqout = BID_NONE;
        cmdout = CMD_IDLE;
        lenout = 2'b00;
        addrdataout = '0;
        if (state == F_BID) begin
            reqout = (fifo_level < URGENT_LEVEL) ? BID_HIGH : BID_LOW;
        end
        if (state == F_CMD) begin
            cmdout = CMD_READ;
            lenout = BURST_LEN;
            addrdataout = addr;
        end
    end

endmodule

`default_nettype wire

// ==== source/pixel_fifo.sv ====
`default_nettype none

module pixel_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         wr_en,
    input  video_pkg::pixel_t            wr_data,
    input  logic                         rd_en,
    output video_pkg::pixel_t            rd_data,
    output logic                         empty,
    output logic [$clog2(FIFO_DEPTH):0]  level,
    output logic                         underflow
);
    import video_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    pixel_t mem [FIFO_DEPTH];

    // Extra top bit tells a full queue from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        do_write;
    logic        do_read;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign level = wr_ptr - rd_ptr;

    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;

    assign rd_data = mem[rd_ptr[AW-1:0]]; // Head of queue, no read latency

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Sticky until the next reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            underflow <= 1'b0;
        end else if (rd_en && empty) begin
            underflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/video_timing.sv ====
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT = 16,
    parameter int H_SYNC = 96,
    parameter int H_BACK = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT = 10,
    parameter int V_SYNC = 2,
    parameter int V_BACK = 33
) (
    input  logic clk,
    input  logic reset_n,
    input  logic enable,
    output logic h_sync,
    output logic h_blank,
    output logic v_sync,
    output logic v_blank,
    output logic pixel_active
);
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    // Sync windows, start inclusive and end exclusive
    localparam logic [HW-1:0] H_SYNC_START = HW'(H_ACTIVE + H_FRONT);
    localparam logic [HW-1:0] H_SYNC_END = HW'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [VW-1:0] V_SYNC_START = VW'(V_ACTIVE + V_FRONT);
    localparam logic [VW-1:0] V_SYNC_END = VW'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          line_end;
    logic          frame_end;
    logic          h_act;
    logic          v_act;

    assign line_end = (h_cnt == HW'(H_TOTAL - 1));
    assign frame_end = (v_cnt == VW'(V_TOTAL - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!enable) begin
            h_cnt <= '0; // Park at the frame origin
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_act = (h_cnt < HW'(H_ACTIVE));
    assign v_act = (v_cnt < VW'(V_ACTIVE));

    // Everything stays low while disabled
    assign h_blank = enable && !h_act;
    assign v_blank = enable && !v_act;
    assign h_sync = enable && (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
    assign v_sync = enable && (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
    assign pixel_active = enable && h_act && v_act;

endmodule

`default_nettype wire

// ==== source/pixel_out.sv ====
`default_nettype none

module pixel_out (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             h_sync,
    input  logic                             h_blank,
    input  logic                             v_sync,
    input  logic                             v_blank,
    input  logic                             pixel_active,
    input  video_pkg::pixel_t                rd_data,
    input  logic                             empty,
    output logic                             rd_en,
    output logic                             hsync,
    output logic                             hblank,
    output logic                             vsync,
    output logic                             vblank,
    output logic [video_pkg::COLOR_W-1:0]    r,
    output logic [video_pkg::COLOR_W-1:0]    g,
    output logic [video_pkg::COLOR_W-1:0]    b
);
    import video_pkg::*;

    pixel_t pixel;

    // One pop per active position, the FIFO drops it when empty
    assign rd_en = pixel_active;

    assign pixel = (pixel_active && !empty) ? rd_data : BLACK;

    // Syncs and colour leave together, one cycle after the position
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hsync <= 1'b0;
            hblank <= 1'b0;
            vsync <= 1'b0;
            vblank <= 1'b0;
            r <= '0;
            g <= '0;
            b <= '0;
        end else begin
            hsync <= h_sync;
            hblank <= h_blank;
            vsync <= v_sync;
            vblank <= v_blank;
            r <= pixel.red;
            g <= pixel.green;
            b <= pixel.blue;
        end
    end

endmodule

`default_nettype wire

// ==== source/video_out.sv ====
`default_nettype none

module video_out #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT = 16,
    parameter int H_SYNC = 96,
    parameter int H_BACK = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT = 10,
    parameter int V_SYNC = 2,
    parameter int V_BACK = 33,
    parameter int FIFO_DEPTH = 64,
    parameter bus_pkg::bus_word_t FRAME_BASE = 32'h0000_0000
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             enable,
    input  logic                             selin,
    input  bus_pkg::bus_cmd_t                cmdin,
    input  bus_pkg::bus_word_t               addrdatain,
    input  logic                             ackin,
    output bus_pkg::bus_bid_t                reqout,
    output bus_pkg::bus_cmd_t                cmdout,
    output logic [1:0]                       lenout,
    output bus_pkg::bus_word_t               addrdataout,
    output logic                             hsync,
    output logic                             hblank,
    output logic                             vsync,
    output logic                             vblank,
    output logic [video_pkg::COLOR_W-1:0]    r,
    output logic [video_pkg::COLOR_W-1:0]    g,
    output logic [video_pkg::COLOR_W-1:0]    b,
    output logic                             underflow
);
    import video_pkg::*;

    logic [$clog2(FIFO_DEPTH):0] fifo_level;
    logic                        wr_en;
    pixel_t                      wr_data;
    logic                        rd_en;
    pixel_t                      rd_data;
    logic                        empty;
    logic                        h_sync;
    logic                        h_blank;
    logic                        v_sync;
    logic                        v_blank;
    logic                        pixel_active;

    frame_fetch #(
        .H_ACTIVE   (H_ACTIVE),
        .V_ACTIVE   (V_ACTIVE),
        .FIFO_DEPTH (FIFO_DEPTH),
        .FRAME_BASE (FRAME_BASE)
    ) frame_fetch_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .selin       (selin),
        .cmdin       (cmdin),
        .addrdatain  (addrdatain),
        .ackin       (ackin),
        .fifo_level  (fifo_level),
        .reqout      (reqout),
        .cmdout      (cmdout),
        .lenout      (lenout),
        .addrdataout (addrdataout),
        .wr_en       (wr_en),
        .wr_data     (wr_data)
    );

    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) pixel_fifo_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .empty     (empty),
        .level     (fifo_level),
        .underflow (underflow)
    );

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) video_timing_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable       (enable),
        .h_sync       (h_sync),
        .h_blank      (h_blank),
        .v_sync       (v_sync),
        .v_blank      (v_blank),
        .pixel_active (pixel_active)
    );

    pixel_out pixel_out_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .h_sync       (h_sync),
        .h_blank      (h_blank),
        .v_sync       (v_sync),
        .v_blank      (v_blank),
        .pixel_active (pixel_active),
        .rd_data      (rd_data),
        .empty        (empty),
        .rd_en        (rd_en),
        .hsync        (hsync),
        .hblank       (hblank),
        .vsync        (vsync),
        .vblank       (vblank),
        .r            (r),
        .g            (g),
        .b            (b)
    );

endmodule

`default_nettype wire

// ==== bench/video_out_asserts.sv ====
`default_nettype none

module video_out_asserts #(
    parameter int FIFO_DEPTH = 64
) (
    input logic                        clk,
    input logic                        reset_n,
    input video_pkg::fetch_state_t     state,
    input bus_pkg::bus_bid_t           reqout,
    input logic                        ackin,
    input bus_pkg::bus_cmd_t           cmdout,
    input logic                        wr_en,
    input logic [$clog2(FIFO_DEPTH):0] fifo_level
);
    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;
    import video_pkg::*;

    localparam int LW = $clog2(FIFO_DEPTH) + 1;

    // Bid stays up until granted
    assert property (@(posedge clk) disable iff (!reset_n)
        (reqout != BID_NONE && !ackin) |=> (reqout != BID_NONE))
        else $error("bid dropped before the grant");

    assert property (@(posedge clk) disable iff (!reset_n)
        (reqout != BID_NONE && ackin) |=> (cmdout == CMD_READ))
        else $error("grant not followed by a command beat");

    assert property (@(posedge clk) disable iff (!reset_n)
        (cmdout == CMD_READ) |=> (cmdout == CMD_IDLE))
        else $error("command beat longer than one cycle");

    // Whole burst fits while bidding
    assert property (@(posedge clk) disable iff (!reset_n)
        (state == F_BID) |-> (fifo_level <= LW'(FIFO_DEPTH - BURST_BEATS)))
        else $error("bid without room for a full burst");

    assert property (@(posedge clk) disable iff (!reset_n)
        wr_en |-> (fifo_level < LW'(FIFO_DEPTH)))
        else $error("write into a full FIFO");

endmodule

bind frame_fetch video_out_asserts #(
    .FIFO_DEPTH (FIFO_DEPTH)
) video_out_asserts_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .state      (state),
    .reqout     (reqout),
    .ackin      (ackin),
    .cmdout     (cmdout),
    .wr_en      (wr_en),
    .fifo_level (fifo_level)
);

`default_nettype wire

// ==== bench/video_out_tb.sv ====
`default_nettype none

module video_out_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;
    import video_pkg::*;

    localparam int H_ACTIVE = 8;
    localparam int H_FRONT = 2;
    localparam int H_SYNC = 2;
    localparam int H_BACK = 2;
    localparam int V_ACTIVE = 4;
    localparam int V_FRONT = 1;
    localparam int V_SYNC = 1;
    localparam int V_BACK = 1;
    localparam int FIFO_DEPTH = 16;
    localparam bus_word_t FRAME_BASE = 32'h0003_5c40;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE;
    localparam int WAIT_LIMIT = 1000; // Cycles before a wait gives up

    logic clk;
    logic reset_n;
    logic enable;
    logic selin;
    bus_cmd_t cmdin;
    bus_word_t addrdatain;
    logic ackin;
    bus_bid_t reqout;
    bus_cmd_t cmdout;
    logic [1:0] lenout;
    bus_word_t addrdataout;
    logic hsync;
    logic hblank;
    logic vsync;
    logic vblank;
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
    logic underflow;

    integer seed;
    logic slow_mem;
    int beats_written = 0;
    int written_seen = 0;
    int popped = 0;
    logic underflow_exp = 1'b0;

    video_out #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .FIFO_DEPTH (FIFO_DEPTH), .FRAME_BASE (FRAME_BASE)
    ) video_out_inst (
        .clk (clk), .reset_n (reset_n), .enable (enable),
        .selin (selin), .cmdin (cmdin), .addrdatain (addrdatain), .ackin (ackin),
        .reqout (reqout), .cmdout (cmdout), .lenout (lenout), .addrdataout (addrdataout),
        .hsync (hsync), .hblank (hblank), .vsync (vsync), .vblank (vblank),
        .r (r), .g (g), .b (b), .underflow (underflow)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk; // 40 ns period

    // Frame buffer contents, a scramble of the full word address
    function automatic pixel_t pixel_at(input bus_word_t addr);
        bus_word_t mix;
        mix = addr ^ (addr >> 11) ^ 32'h00a5_3c96;
        return pixel_t'(mix[23:0]);
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_cmd(input string name, input bus_cmd_t got, input bus_cmd_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_bid(input string name, input bus_bid_t got, input bus_bid_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_word(input string name, input bus_word_t got, input bus_word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_len(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // Beats land in the FIFO at the rising edge after they are driven
    always @(posedge clk) begin
        if (selin && cmdin == CMD_RESP) beats_written <= beats_written + 1;
    end

    task automatic check_idle_outputs();
        compare_bit("hsync", hsync, 1'b0);
        compare_bit("hblank", hblank, 1'b0);
        compare_bit("vsync", vsync, 1'b0);
        compare_bit("vblank", vblank, 1'b0);
        compare_pixel("rgb", pixel_t'({r, g, b}), BLACK);
        compare_bit("underflow", underflow, 1'b0);
    endtask

    // Output of each raster position shows one cycle later
    task automatic follow_raster(input int frames);
        int h;
        int v;
        int avail;
        logic active;
        pixel_t expected;
        for (int p = 0; p < frames * H_TOTAL * V_TOTAL; p++) begin
            h = p % H_TOTAL;
            v = p / H_TOTAL % V_TOTAL;
            active = (h < H_ACTIVE) && (v < V_ACTIVE);
            avail = written_seen;
            @(negedge clk);
            written_seen = beats_written;
            compare_bit("hblank", hblank, h >= H_ACTIVE);
            compare_bit("vblank", vblank, v >= V_ACTIVE);
            compare_bit("hsync", hsync, h >= H_ACTIVE + H_FRONT && h < H_TOTAL - H_BACK);
            compare_bit("vsync", vsync, v >= V_ACTIVE + V_FRONT && v < V_TOTAL - V_BACK);
            expected = BLACK;
            if (active && avail > popped) begin
                expected = pixel_at(FRAME_BASE + bus_word_t'(popped % FRAME_WORDS));
                popped++;
            end else if (active) begin
                underflow_exp = 1'b1; // Nothing queued for this position
            end
            compare_pixel("rgb", pixel_t'({r, g, b}), expected);
            compare_bit("underflow", underflow, underflow_exp);
        end
    endtask

    // Bus memory, grants bids and answers one burst at a time
    initial begin : memory_model
        bus_word_t exp_addr;
        bus_word_t addr;
        int wait_cnt;
        int gap;
        exp_addr = FRAME_BASE;
        @(posedge reset_n);
        forever begin
            wait_cnt = 0;
            while (reqout == BID_NONE) begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) fail_now("timeout waiting for a bus bid");
            end
            gap = slow_mem ? 8 : ($random(seed) & 1);
            repeat (gap) @(negedge clk);
            ackin = 1'b1;
            @(negedge clk);
            ackin = 1'b0;
            compare_cmd("cmdout", cmdout, CMD_READ);
            compare_len("lenout", lenout, 2'(BURST_BEATS - 1));
            compare_word("addrdataout", addrdataout, exp_addr);
            addr = addrdataout;
            exp_addr = exp_addr + BURST_BEATS;
            if (exp_addr == FRAME_BASE + FRAME_WORDS) exp_addr = FRAME_BASE;
            for (int i = 0; i < BURST_BEATS; i++) begin
                gap = slow_mem ? 2 * H_TOTAL : ((($random(seed) & 7) == 0) ? 1 : 0);
                repeat (gap + 1) begin
                    @(negedge clk);
                    selin = 1'b0;
                    cmdin = CMD_IDLE;
                    compare_bid("reqout", reqout, BID_NONE); // Burst still open
                end
                selin = 1'b1;
                cmdin = CMD_RESP;
                addrdatain = {addr[31:24] ^ 8'h5a, pixel_at(addr)};
                addr++;
            end
            @(negedge clk);
            selin = 1'b0;
            cmdin = CMD_IDLE;
        end
    end

    initial begin : main_sequence
        int wait_cnt;
        seed = 32'hfb9a199a;
        reset_n = 1'b0;
        enable = 1'b0;
        selin = 1'b0;
        cmdin = CMD_IDLE;
        addrdatain = '0;
        ackin = 1'b0;
        slow_mem = 1'b0;
        repeat (16) @(negedge clk);
        compare_bid("reqout", reqout, BID_NONE);
        compare_cmd("cmdout", cmdout, CMD_IDLE);
        check_idle_outputs();
        reset_n = 1'b1;

        // Display parked while the FIFO fills
        wait_cnt = 0;
        while (beats_written < FIFO_DEPTH) begin
            @(negedge clk);
            check_idle_outputs();
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) fail_now("timeout waiting for the FIFO prefill");
        end
        repeat (8) begin
            @(negedge clk);
            check_idle_outputs();
        end

        enable = 1'b1;
        written_seen = beats_written;
        follow_raster(3);
        compare_bit("underflow", underflow, 1'b0);

        slow_mem = 1'b1; // Gaps longer than a line
        follow_raster(2);
        compare_bit("underflow", underflow, 1'b1);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== video_out.f ====
source/bus_pkg.sv
source/video_pkg.sv
source/frame_fetch.sv
source/pixel_fifo.sv
source/video_timing.sv
source/pixel_out.sv
source/video_out.sv
bench/video_out_asserts.sv
bench/video_out_tb.sv

// ==== Makefile ====
TOP = video_out_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

# A missing pass line also counts as failure, e.g. after an assertion stop
test:
	verilator --binary --timing --assert -f video_out.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
